// ==== Bender.yml ====
package:
  name: token_engine

sources:
  - rtl/token_pkg.sv
  - rtl/glb_req_if.sv
  - rtl/pass_controller.sv
  - rtl/weight_loader.sv
  - rtl/lane_fifo_ctrl.sv
  - rtl/token_arbiter.sv
  - rtl/token_engine.sv
  - target: simulation
    files:
      - verif/tb_token_engine.sv

// ==== build.f ====
rtl/token_pkg.sv
rtl/glb_req_if.sv
rtl/pass_controller.sv
rtl/weight_loader.sv
rtl/lane_fifo_ctrl.sv
rtl/token_arbiter.sv
rtl/token_engine.sv
verif/tb_token_engine.sv

// ==== rtl/glb_req_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// one requester's GLB access and its grant
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

interface glb_req_if import token_pkg::*; #(
    parameter int AW = ADDR_W,
    parameter int DW = WORD_W,
    parameter int BW = WEB_W
) ();

    logic          req;     // held until gnt seen at an edge
    logic          we;      // 1 write, 0 read
    logic [AW-1:0] addr;
    logic [DW-1:0] wdata;
    logic [BW-1:0] web;
    logic          gnt;     // the granted edge performs the access

    modport requester (output req, we, addr, wdata, web, input gnt);

    modport arbiter (input req, we, addr, wdata, web, output gnt);

endinterface

// ==== rtl/lane_fifo_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// per-lane ifmap fetch counters
// opsum pop, capture and write back
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module lane_fifo_ctrl import token_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,

    input  pass_phase_t       phase_i,
    input  logic [ADDR_W-1:0] ifmap_base_addr_i,
    input  logic [ADDR_W-1:0] lane_stride_i,
    input  logic [LEN_W-1:0]  tile_len_i,
    input  logic [ADDR_W-1:0] opsum_base_addr_i,

    input  lane_vec_t         fill_push_i,
    input  logic [WORD_W-1:0] glb_read_data_i,
    input  lane_vec_t         ifmap_fifo_full_i,
    input  lane_vec_t         opsum_fifo_empty_i,
    input  logic [WORD_W-1:0] opsum_fifo_data_i,

    glb_req_if.requester      ifmap_req [NUM_LANE],
    glb_req_if.requester      opsum_req [NUM_LANE],

    output lane_vec_t         ifmap_fifo_push_o,
    output logic [WORD_W-1:0] ifmap_fifo_push_data_o,
    output lane_vec_t         opsum_fifo_pop_o,
    output logic              fill_done_o,
    output logic              drain_done_o
);

    lane_vec_t lane_filled;    // every ifmap word returned
    lane_vec_t lane_written;   // opsum write granted
    lane_vec_t pop_cand;
    lane_vec_t pop_pick;
    lane_vec_t pop_q;
    lane_vec_t cap_q;          // opsum data valid this cycle
    lane_vec_t popped_q;

    // returning ifmap word is pushed in the cycle it arrives
    assign ifmap_fifo_push_o      = fill_push_i;
    assign ifmap_fifo_push_data_o = glb_read_data_i;
    assign opsum_fifo_pop_o       = pop_q;

    genvar l;
    for (l = 0; l < NUM_LANE; l++) begin : g_lane
        logic [LEN_W-1:0]  iss_cnt;
        logic [LEN_W-1:0]  ret_cnt;
        logic [ADDR_W-1:0] lane_base;
        logic [WORD_W-1:0] opsum_word;
        logic              wr_pend;
        logic              wr_done;

        assign lane_base = ifmap_base_addr_i + ADDR_W'(l) * lane_stride_i;

        // one read in flight per lane so a full flag is never overrun
        assign ifmap_req[l].req   = (phase_i == FILL) && (iss_cnt < tile_len_i)
                                    && (iss_cnt == ret_cnt) && !ifmap_fifo_full_i[l];
        assign ifmap_req[l].we    = 1'b0;
        assign ifmap_req[l].addr  = lane_base + ADDR_W'(iss_cnt) * ADDR_W'(WORD_BYTES);
        assign ifmap_req[l].wdata = '0;
        assign ifmap_req[l].web   = '0;

        always_ff @(posedge clk) begin
            if (!rst_n_i) begin
                iss_cnt <= '0;
                ret_cnt <= '0;
            end else if (phase_i == IDLE) begin
                iss_cnt <= '0;
                ret_cnt <= '0;
            end else begin
                if (ifmap_req[l].gnt) begin
                    iss_cnt <= iss_cnt + 1'b1;
                end
                if (fill_push_i[l]) begin
                    ret_cnt <= ret_cnt + 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (cap_q[l]) begin
                opsum_word <= opsum_fifo_data_i;
            end
        end

        always_ff @(posedge clk) begin
            if (!rst_n_i) begin
                wr_pend <= 1'b0;
                wr_done <= 1'b0;
            end else if (phase_i == IDLE) begin
                wr_pend <= 1'b0;
                wr_done <= 1'b0;
            end else if (cap_q[l]) begin
                wr_pend <= 1'b1;
            end else if (opsum_req[l].gnt) begin
                wr_pend <= 1'b0;
                wr_done <= 1'b1;
            end
        end

        assign opsum_req[l].req   = wr_pend;
        assign opsum_req[l].we    = 1'b1;
        assign opsum_req[l].addr  = opsum_base_addr_i + ADDR_W'(l) * ADDR_W'(WORD_BYTES);
        assign opsum_req[l].wdata = opsum_word;
        assign opsum_req[l].web   = '1;

        assign lane_filled[l]  = (ret_cnt == tile_len_i);
        assign lane_written[l] = wr_done;
    end

    // opsum data bus is shared, so one pop at a time, lowest lane first
    assign pop_cand = ~popped_q & ~opsum_fifo_empty_i;
    assign pop_pick = pop_cand & (~pop_cand + 1'b1);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pop_q    <= '0;
            cap_q    <= '0;
            popped_q <= '0;
        end else begin
            cap_q <= pop_q;   // fifo shows the word one cycle after the pop
            if ((phase_i == DRAIN) && (pop_q == '0)) begin
                pop_q    <= pop_pick;
                popped_q <= popped_q | pop_pick;
            end else begin
                pop_q <= '0;
            end
            if (phase_i == IDLE) begin
                popped_q <= '0;
            end
        end
    end

    assign fill_done_o  = (phase_i == FILL) && (&lane_filled);
    assign drain_done_o = (phase_i == DRAIN) && (&lane_written);

endmodule

// ==== rtl/pass_controller.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// pass phase FSM
// IDLE -> WEIGHT -> FILL -> DRAIN -> IDLE
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module pass_controller import token_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,

    input  logic        pass_start_i,
    input  logic        weight_done_i,
    input  logic        fill_done_i,
    input  logic        drain_done_i,

    output pass_phase_t phase_o,
    output logic        pass_done_o
);

    pass_phase_t phase_q;
    pass_phase_t phase_d;

    // each phase only leaves on its own done pulse
    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            IDLE: begin
                if (pass_start_i) begin
                    phase_d = WEIGHT;
                end
            end
            WEIGHT: begin
                if (weight_done_i) begin
                    phase_d = FILL;
                end
            end
            FILL: begin
                if (fill_done_i) begin
                    phase_d = DRAIN;
                end
            end
            DRAIN: begin
                if (drain_done_i) begin
                    phase_d = IDLE;
                end
            end
            default: begin
                phase_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            phase_q     <= IDLE;
            pass_done_o <= 1'b0;
        end else begin
            phase_q     <= phase_d;
            pass_done_o <= (phase_q == DRAIN) && drain_done_i; // same edge as return to IDLE
        end
    end

    assign phase_o = phase_q;

endmodule

// ==== rtl/token_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// fixed-priority GLB arbiter
// read return steering
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module token_arbiter import token_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,

    glb_req_if.arbiter        weight_req,
    glb_req_if.arbiter        ifmap_req [NUM_LANE],
    glb_req_if.arbiter        opsum_req [NUM_LANE],

    output logic              glb_read_o,
    output logic [ADDR_W-1:0] glb_addr_o,
    output logic [WEB_W-1:0]  glb_web_o,
    output logic [WORD_W-1:0] glb_write_data_o,

    output logic              weight_rdata_valid_o,
    output lane_vec_t         fill_push_o
);

    // all requesters flattened into slots: weight, opsum lanes, ifmap lanes
    logic [NUM_REQ-1:0]   req_vec;
    logic [NUM_REQ-1:0]   we_vec;
    logic [NUM_REQ-1:0]   gnt_vec;
    logic [ADDR_W-1:0]    addr_arr  [NUM_REQ];
    logic [WORD_W-1:0]    wdata_arr [NUM_REQ];
    logic [WEB_W-1:0]     web_arr   [NUM_REQ];
    logic [REQ_IDX_W-1:0] sel;
    logic                 any_req;

    assign req_vec[WEIGHT_SLOT]   = weight_req.req;
    assign we_vec[WEIGHT_SLOT]    = weight_req.we;
    assign addr_arr[WEIGHT_SLOT]  = weight_req.addr;
    assign wdata_arr[WEIGHT_SLOT] = weight_req.wdata;
    assign web_arr[WEIGHT_SLOT]   = weight_req.web;
    assign weight_req.gnt         = gnt_vec[WEIGHT_SLOT];

    genvar l;
    for (l = 0; l < NUM_LANE; l++) begin : g_slot
        assign req_vec[OPSUM_SLOT+l]   = opsum_req[l].req;
        assign we_vec[OPSUM_SLOT+l]    = opsum_req[l].we;
        assign addr_arr[OPSUM_SLOT+l]  = opsum_req[l].addr;
        assign wdata_arr[OPSUM_SLOT+l] = opsum_req[l].wdata;
        assign web_arr[OPSUM_SLOT+l]   = opsum_req[l].web;
        assign opsum_req[l].gnt        = gnt_vec[OPSUM_SLOT+l];

        assign req_vec[IFMAP_SLOT+l]   = ifmap_req[l].req;
        assign we_vec[IFMAP_SLOT+l]    = ifmap_req[l].we;
        assign addr_arr[IFMAP_SLOT+l]  = ifmap_req[l].addr;
        assign wdata_arr[IFMAP_SLOT+l] = ifmap_req[l].wdata;
        assign web_arr[IFMAP_SLOT+l]   = ifmap_req[l].web;
        assign ifmap_req[l].gnt        = gnt_vec[IFMAP_SLOT+l];
    end

    assign any_req = |req_vec;
    assign gnt_vec = req_vec & (~req_vec + 1'b1);   // lowest slot only

    always_comb begin
        sel = '0;
        for (int i = NUM_REQ - 1; i >= 0; i--) begin
            if (req_vec[i]) begin
                sel = REQ_IDX_W'(i);
            end
        end
    end

    assign glb_read_o       = any_req && !we_vec[sel];
    assign glb_web_o        = (any_req && we_vec[sel]) ? web_arr[sel] : '0;
    assign glb_addr_o       = addr_arr[sel];
    assign glb_write_data_o = wdata_arr[sel];

    // read data comes back the cycle after the grant edge
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            weight_rdata_valid_o <= 1'b0;
            fill_push_o          <= '0;
        end else begin
            weight_rdata_valid_o <= gnt_vec[WEIGHT_SLOT] & ~we_vec[WEIGHT_SLOT];
            fill_push_o          <= gnt_vec[IFMAP_SLOT +: NUM_LANE]
                                    & ~we_vec[IFMAP_SLOT +: NUM_LANE];
        end
    end

endmodule

// ==== rtl/token_engine.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// token engine top level
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module token_engine import token_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,

    input  logic              pass_start_i,
    output logic              pass_done_o,

    input  logic [ADDR_W-1:0] weight_base_addr_i,
    input  logic [ADDR_W-1:0] ifmap_base_addr_i,
    input  logic [ADDR_W-1:0] lane_stride_i,
    input  logic [LEN_W-1:0]  tile_len_i,
    input  logic [ADDR_W-1:0] opsum_base_addr_i,

    // GLB
    input  logic [WORD_W-1:0] glb_read_data_i,
    output logic              glb_read_o,
    output logic [ADDR_W-1:0] glb_addr_o,
    output logic [WEB_W-1:0]  glb_web_o,
    output logic [WORD_W-1:0] glb_write_data_o,

    // PE weights
    output logic [WORD_W-1:0] weight_data_o,
    output lane_vec_t         weight_load_en_o,

    // lane fifos
    output lane_vec_t         ifmap_fifo_push_o,
    output logic [WORD_W-1:0] ifmap_fifo_push_data_o,
    input  lane_vec_t         ifmap_fifo_full_i,
    output lane_vec_t         opsum_fifo_pop_o,
    input  logic [WORD_W-1:0] opsum_fifo_data_i,
    input  lane_vec_t         opsum_fifo_empty_i
);

    pass_phase_t phase;
    logic        weight_done;
    logic        fill_done;
    logic        drain_done;
    logic        weight_rdata_valid;
    lane_vec_t   fill_push;

    glb_req_if weight_req ();
    glb_req_if ifmap_req [NUM_LANE] ();
    glb_req_if opsum_req [NUM_LANE] ();

    pass_controller u_pass_controller (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .pass_start_i  (pass_start_i),
        .weight_done_i (weight_done),
        .fill_done_i   (fill_done),
        .drain_done_i  (drain_done),
        .phase_o       (phase),
        .pass_done_o   (pass_done_o)
    );

    weight_loader u_weight_loader (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .phase_i            (phase),
        .weight_base_addr_i (weight_base_addr_i),
        .rdata_valid_i      (weight_rdata_valid),
        .glb_read_data_i    (glb_read_data_i),
        .glb                (weight_req),
        .weight_data_o      (weight_data_o),
        .weight_load_en_o   (weight_load_en_o),
        .weight_done_o      (weight_done)
    );

    lane_fifo_ctrl u_lane_fifo_ctrl (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .phase_i                (phase),
        .ifmap_base_addr_i      (ifmap_base_addr_i),
        .lane_stride_i          (lane_stride_i),
        .tile_len_i             (tile_len_i),
        .opsum_base_addr_i      (opsum_base_addr_i),
        .fill_push_i            (fill_push),
        .glb_read_data_i        (glb_read_data_i),
        .ifmap_fifo_full_i      (ifmap_fifo_full_i),
        .opsum_fifo_empty_i     (opsum_fifo_empty_i),
        .opsum_fifo_data_i      (opsum_fifo_data_i),
        .ifmap_req              (ifmap_req),
        .opsum_req              (opsum_req),
        .ifmap_fifo_push_o      (ifmap_fifo_push_o),
        .ifmap_fifo_push_data_o (ifmap_fifo_push_data_o),
        .opsum_fifo_pop_o       (opsum_fifo_pop_o),
        .fill_done_o            (fill_done),
        .drain_done_o           (drain_done)
    );

    token_arbiter u_token_arbiter (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .weight_req           (weight_req),
        .ifmap_req            (ifmap_req),
        .opsum_req            (opsum_req),
        .glb_read_o           (glb_read_o),
        .glb_addr_o           (glb_addr_o),
        .glb_web_o            (glb_web_o),
        .glb_write_data_o     (glb_write_data_o),
        .weight_rdata_valid_o (weight_rdata_valid),
        .fill_push_o          (fill_push)
    );

endmodule

// ==== rtl/token_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// token engine sizes, requester slots,
// pass phase encoding and lane vector type
// ~~~~~~~~~~~~~~~~~~~~

package token_pkg;

    // array and bus sizes
    localparam int NUM_LANE     = 4;
    localparam int WORD_W       = 32;
    localparam int ADDR_W       = 32;
    localparam int WEB_W        = 4;
    localparam int WORD_BYTES   = 4;    // byte step between words
    localparam int LEN_W        = 8;    // per-lane ifmap word count

    // weight block, one word per lane
    localparam int WEIGHT_WORDS = 4;
    localparam int WCNT_W       = $clog2(WEIGHT_WORDS + 1);

    // GLB requester slots, lower slot wins
    localparam int NUM_REQ      = 1 + 2 * NUM_LANE;
    localparam int REQ_IDX_W    = $clog2(NUM_REQ);
    localparam int WEIGHT_SLOT  = 0;
    localparam int OPSUM_SLOT   = 1;              // first opsum lane
    localparam int IFMAP_SLOT   = 1 + NUM_LANE;   // first ifmap lane

    typedef enum logic [1:0] {
        IDLE,
        WEIGHT,   // weight block load
        FILL,     // ifmap fifo fill
        DRAIN     // opsum write back
    } pass_phase_t;

    typedef logic [NUM_LANE-1:0] lane_vec_t;

endpackage

// ==== rtl/weight_loader.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// weight block reader and
// lane load-enable steering
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module weight_loader import token_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,

    input  pass_phase_t       phase_i,
    input  logic [ADDR_W-1:0] weight_base_addr_i,

    input  logic              rdata_valid_i,
    input  logic [WORD_W-1:0] glb_read_data_i,
    glb_req_if.requester      glb,

    output logic [WORD_W-1:0] weight_data_o,
    output lane_vec_t         weight_load_en_o,
    output logic              weight_done_o
);

    logic [WCNT_W-1:0] issue_cnt;   // reads granted so far
    logic [WCNT_W-1:0] ret_cnt;     // words handed to lanes

    // read request, fields only move on a grant
    assign glb.req   = (phase_i == WEIGHT) && (issue_cnt < WCNT_W'(WEIGHT_WORDS));
    assign glb.we    = 1'b0;
    assign glb.addr  = weight_base_addr_i + ADDR_W'(issue_cnt) * ADDR_W'(WORD_BYTES);
    assign glb.wdata = '0;
    assign glb.web   = '0;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            issue_cnt <= '0;
            ret_cnt   <= '0;
        end else if (phase_i == IDLE) begin
            issue_cnt <= '0;  // fresh block every pass
            ret_cnt   <= '0;
        end else begin
            if (glb.gnt) begin
                issue_cnt <= issue_cnt + 1'b1;
            end
            if (rdata_valid_i) begin
                ret_cnt <= ret_cnt + 1'b1;
            end
        end
    end

    // word k goes to lane k
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            weight_load_en_o <= '0;
            weight_done_o    <= 1'b0;
        end else begin
            weight_load_en_o <= rdata_valid_i ? (lane_vec_t'(1) << ret_cnt) : '0;
            weight_done_o    <= rdata_valid_i && (ret_cnt == WCNT_W'(WEIGHT_WORDS - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (rdata_valid_i) begin
            weight_data_o <= glb_read_data_i;
        end
    end

endmodule

// ==== verif/tb_token_engine.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// token engine testbench
// GLB and lane FIFO models, pass table, checks
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_token_engine import token_pkg::*; ();

    localparam int NUM_ROWS = 3;
    localparam int TIMEOUT  = 3000;   // cycles per pass

    typedef struct packed {
        logic [ADDR_W-1:0]               w_base;
        logic [ADDR_W-1:0]               i_base;
        logic [ADDR_W-1:0]               stride;
        logic [LEN_W-1:0]                len;
        logic [ADDR_W-1:0]               o_base;
        logic [NUM_LANE-1:0][WORD_W-1:0] exp_weight;   // lane 3 first
        logic [NUM_LANE-1:0][ADDR_W-1:0] exp_if_addr;  // first ifmap word of each lane
        logic [NUM_LANE-1:0][WORD_W-1:0] opsum_word;   // also the expected write data
        logic [NUM_LANE-1:0][ADDR_W-1:0] exp_wr_addr;
    } pass_row_t;

    logic              clk;
    logic              rst_n_i;
    logic              pass_start_i;
    logic              pass_done_o;
    logic [ADDR_W-1:0] weight_base_addr_i;
    logic [ADDR_W-1:0] ifmap_base_addr_i;
    logic [ADDR_W-1:0] lane_stride_i;
    logic [LEN_W-1:0]  tile_len_i;
    logic [ADDR_W-1:0] opsum_base_addr_i;
    logic [WORD_W-1:0] glb_read_data_i;
    logic              glb_read_o;
    logic [ADDR_W-1:0] glb_addr_o;
    logic [WEB_W-1:0]  glb_web_o;
    logic [WORD_W-1:0] glb_write_data_o;
    logic [WORD_W-1:0] weight_data_o;
    lane_vec_t         weight_load_en_o;
    lane_vec_t         ifmap_fifo_push_o;
    logic [WORD_W-1:0] ifmap_fifo_push_data_o;
    lane_vec_t         ifmap_fifo_full_i;
    lane_vec_t         opsum_fifo_pop_o;
    logic [WORD_W-1:0] opsum_fifo_data_i;
    lane_vec_t         opsum_fifo_empty_i;

    pass_row_t rows [NUM_ROWS];
    int        cur;                    // row of the running pass
    int        wload_cnt [NUM_LANE];
    int        push_cnt  [NUM_LANE];
    int        pop_cnt   [NUM_LANE];
    int        wr_cnt    [NUM_LANE];
    int        fifo_lvl  [NUM_LANE];   // ifmap fifo fill level
    int        rel_delay [NUM_LANE];   // cycles until opsum word shows
    logic      armed     [NUM_LANE];
    int        done_cnt;
    int        full_cycles;

    token_engine uut (.*);

    // GLB content is a fixed function of the byte address
    function automatic logic [WORD_W-1:0] glb_word(input logic [ADDR_W-1:0] a);
        return a ^ 32'hA5A5_0000;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic raise_error(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic wait_pass_done();
        int n;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge clk);
            if (pass_done_o) break;
        end
        assert (n < TIMEOUT) else raise_error("timeout waiting for pass_done_o");
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // GLB, ifmap fifo and opsum fifo models plus on-the-fly checks
    always @(posedge clk) begin : models
        int k;
        int hit;
        int pop;
        if (rst_n_i) begin
            if (glb_read_o) begin
                glb_read_data_i <= glb_word(glb_addr_o);   // one cycle latency
            end
            if (glb_web_o != '0) begin
                assert (glb_web_o == '1)
                    else report_mismatch("glb_web_o on write", 32'hF, glb_web_o);
                hit = -1;
                for (int l = 0; l < NUM_LANE; l++) begin
                    if (glb_addr_o == rows[cur].exp_wr_addr[l]) hit = l;
                end
                assert (hit >= 0)
                    else raise_error($sformatf("GLB write to unexpected address %h", glb_addr_o));
                if (hit >= 0) begin
                    assert (glb_write_data_o == rows[cur].opsum_word[hit])
                        else report_mismatch($sformatf("row %0d write lane %0d", cur, hit),
                                             rows[cur].opsum_word[hit], glb_write_data_o);
                    wr_cnt[hit]++;
                end
            end
            if (weight_load_en_o != '0) begin
                assert ($onehot(weight_load_en_o))
                    else raise_error("weight_load_en_o has more than one bit set");
                k = 0;
                for (int l = 0; l < NUM_LANE; l++) begin
                    if (weight_load_en_o[l]) k = l;
                end
                assert (weight_data_o == rows[cur].exp_weight[k])
                    else report_mismatch($sformatf("row %0d weight lane %0d", cur, k),
                                         rows[cur].exp_weight[k], weight_data_o);
                wload_cnt[k]++;
            end
            if (ifmap_fifo_full_i != '0) full_cycles++;
            for (int l = 0; l < NUM_LANE; l++) begin
                if (ifmap_fifo_push_o[l]) begin
                    assert (!ifmap_fifo_full_i[l])
                        else raise_error($sformatf("push into full ifmap fifo, lane %0d", l));
                    assert (push_cnt[l] < int'(rows[cur].len))
                        else raise_error($sformatf("extra ifmap push on lane %0d", l));
                    assert (ifmap_fifo_push_data_o == glb_word(rows[cur].exp_if_addr[l]
                            + ADDR_W'(push_cnt[l] * WORD_BYTES)))
                        else report_mismatch($sformatf("row %0d ifmap lane %0d word %0d",
                                                       cur, l, push_cnt[l]),
                                             glb_word(rows[cur].exp_if_addr[l]
                                                      + ADDR_W'(push_cnt[l] * WORD_BYTES)),
                                             ifmap_fifo_push_data_o);
                    push_cnt[l]++;
                end
                pop = (fifo_lvl[l] > 0 && $urandom_range(2) == 0) ? 1 : 0;   // PE consumes
                fifo_lvl[l] = fifo_lvl[l] + int'(ifmap_fifo_push_o[l]) - pop;
                ifmap_fifo_full_i[l] <= (fifo_lvl[l] >= 2);
                if (opsum_fifo_pop_o[l]) begin
                    assert (armed[l] && !opsum_fifo_empty_i[l])
                        else raise_error($sformatf("pop from empty opsum fifo, lane %0d", l));
                    pop_cnt[l]++;
                    armed[l] = 1'b0;
                    opsum_fifo_empty_i[l] <= 1'b1;
                    opsum_fifo_data_i     <= rows[cur].opsum_word[l];   // word follows the pop
                end else if (pass_start_i) begin
                    armed[l]     = 1'b1;
                    rel_delay[l] = 10 + $urandom_range(90);
                end else if (armed[l]) begin
                    if (rel_delay[l] == 0) opsum_fifo_empty_i[l] <= 1'b0;
                    else rel_delay[l]--;
                end
            end
            if (pass_done_o) begin
                done_cnt++;
                for (int l = 0; l < NUM_LANE; l++) begin
                    assert (wr_cnt[l] == 1)
                        else report_mismatch($sformatf("row %0d writes before done, lane %0d",
                                                       cur, l), 1, wr_cnt[l]);
                end
            end
        end
    end

    initial begin : stimulus
        void'($urandom(32'h7b5d));
        rows[0] = '{w_base: 32'h0000_1000, i_base: 32'h0000_2000, stride: 32'h40, len: 8'd1,
            o_base: 32'h0000_3000,
            exp_weight:  {32'hA5A5_100C, 32'hA5A5_1008, 32'hA5A5_1004, 32'hA5A5_1000},
            exp_if_addr: {32'h0000_20C0, 32'h0000_2080, 32'h0000_2040, 32'h0000_2000},
            opsum_word:  {32'hC0DE_0003, 32'hC0DE_0002, 32'hC0DE_0001, 32'hC0DE_0000},
            exp_wr_addr: {32'h0000_300C, 32'h0000_3008, 32'h0000_3004, 32'h0000_3000}};
        rows[1] = '{w_base: 32'h0001_0100, i_base: 32'h0002_0000, stride: 32'h100, len: 8'd6,
            o_base: 32'h0003_0010,
            exp_weight:  {32'hA5A4_010C, 32'hA5A4_0108, 32'hA5A4_0104, 32'hA5A4_0100},
            exp_if_addr: {32'h0002_0300, 32'h0002_0200, 32'h0002_0100, 32'h0002_0000},
            opsum_word:  {32'h1234_5678, 32'h9ABC_DEF0, 32'h0F0F_F0F0, 32'h5555_AAAA},
            exp_wr_addr: {32'h0003_001C, 32'h0003_0018, 32'h0003_0014, 32'h0003_0010}};
        rows[2] = '{w_base: 32'h8000_0040, i_base: 32'h0000_4000, stride: 32'h20, len: 8'd8,
            o_base: 32'h0000_5000,
            exp_weight:  {32'h25A5_004C, 32'h25A5_0048, 32'h25A5_0044, 32'h25A5_0040},
            exp_if_addr: {32'h0000_4060, 32'h0000_4040, 32'h0000_4020, 32'h0000_4000},
            opsum_word:  {32'hDEAD_0003, 32'hBEEF_0002, 32'hFACE_0001, 32'hCAFE_0000},
            exp_wr_addr: {32'h0000_500C, 32'h0000_5008, 32'h0000_5004, 32'h0000_5000}};
        rst_n_i            = 1'b0;
        pass_start_i       = 1'b0;
        weight_base_addr_i = '0;
        ifmap_base_addr_i  = '0;
        lane_stride_i      = '0;
        tile_len_i         = '0;
        opsum_base_addr_i  = '0;
        glb_read_data_i    = '0;
        ifmap_fifo_full_i  = '0;
        opsum_fifo_data_i  = '0;
        opsum_fifo_empty_i = '1;
        cur                = 0;
        full_cycles        = 0;
        for (int l = 0; l < NUM_LANE; l++) begin
            fifo_lvl[l]  = 0;
            rel_delay[l] = 0;
            armed[l]     = 1'b0;
        end
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (4) begin
            @(posedge clk);
            assert ({pass_done_o, glb_read_o, glb_web_o, weight_load_en_o,
                     ifmap_fifo_push_o, opsum_fifo_pop_o} == '0)
                else report_mismatch("outputs after reset", 0,
                                     {pass_done_o, glb_read_o, glb_web_o, weight_load_en_o,
                                      ifmap_fifo_push_o, opsum_fifo_pop_o});
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            cur      = r;
            done_cnt = 0;
            for (int l = 0; l < NUM_LANE; l++) begin
                wload_cnt[l] = 0;
                push_cnt[l]  = 0;
                pop_cnt[l]   = 0;
                wr_cnt[l]    = 0;
            end
            @(posedge clk);
            weight_base_addr_i <= rows[r].w_base;
            ifmap_base_addr_i  <= rows[r].i_base;
            lane_stride_i      <= rows[r].stride;
            tile_len_i         <= rows[r].len;
            opsum_base_addr_i  <= rows[r].o_base;
            pass_start_i       <= 1'b1;
            @(posedge clk);
            pass_start_i <= 1'b0;
            wait_pass_done();
            repeat (3) @(posedge clk);   // done must not repeat
            for (int l = 0; l < NUM_LANE; l++) begin
                assert (wload_cnt[l] == 1)
                    else report_mismatch($sformatf("row %0d weight loads lane %0d", r, l),
                                         1, wload_cnt[l]);
                assert (push_cnt[l] == int'(rows[r].len))
                    else report_mismatch($sformatf("row %0d ifmap pushes lane %0d", r, l),
                                         rows[r].len, push_cnt[l]);
                assert (pop_cnt[l] == 1)
                    else report_mismatch($sformatf("row %0d opsum pops lane %0d", r, l),
                                         1, pop_cnt[l]);
            end
            assert (done_cnt == 1)
                else report_mismatch($sformatf("row %0d pass_done pulses", r), 1, done_cnt);
        end
        assert (full_cycles > 0) else raise_error("ifmap full flag never asserted");
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
